//--- design/soc_pkg.sv
`default_nettype none

package soc_pkg;

	typedef logic [31:0] word_t;     // Register values, bus data, instructions
	typedef logic [31:0] addr_t;     // Byte address
	typedef logic [4:0]  reg_idx_t;  // x0..x31
	typedef logic [3:0]  strb_t;     // One bit per byte lane
	typedef logic [11:0] uop_t;      // Microcode word

	// RV32I major opcodes
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_ALUI   = 7'b0010011;
	localparam logic [6:0] OP_ALU    = 7'b0110011;

	// Bit positions inside a microcode word
	localparam int UOP_PSEL      = 0;   // Drive psel
	localparam int UOP_PENABLE   = 1;   // Drive penable, stall until pready
	localparam int UOP_STORE_ALU = 2;   // rd <= ALU result
	localparam int UOP_LOAD_INSR = 3;   // Latch and decode fetched word
	localparam int UOP_MEM       = 4;   // Data access step
	localparam int UOP_BRANCH    = 5;   // Take branch if compare holds
	localparam int UOP_LOAD_PC   = 6;   // JALR jump and link
	localparam int UOP_PWRITE    = 8;   // Write access
	localparam int UOP_IDLE      = 11;  // Instruction done, next cycle fetches

endpackage

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  wire logic [3:0]     op,      // {extra, funct3}
	input  wire soc_pkg::word_t a,
	input  wire soc_pkg::word_t b,
	output soc_pkg::word_t      result,
	output logic                cmp
);

	soc_pkg::word_t sra_res;

	// Cast keeps the shift signed so the sign bit fills in
	assign sra_res = soc_pkg::word_t'($signed(a) >>> b[4:0]);

	always_comb begin
		case (op[2:0])
			3'b000:  result = op[3] ? a - b : a + b;  // SUB when extra bit set
			3'b001:  result = a << b[4:0];
			3'b010:  result = {31'b0, $signed(a) < $signed(b)};
			3'b011:  result = {31'b0, a < b};
			3'b100:  result = a ^ b;
			3'b101:  result = op[3] ? sra_res : a >> b[4:0];
			3'b110:  result = a | b;
			default: result = a & b;
		endcase
	end

	// Branch condition, funct3 encoding of the B-type group
	always_comb begin
		case (op[2:0])
			3'b000:  cmp = (a == b);
			3'b001:  cmp = (a != b);
			3'b100:  cmp = ($signed(a) < $signed(b));
			3'b101:  cmp = ($signed(a) >= $signed(b));
			3'b110:  cmp = (a < b);
			3'b111:  cmp = (a >= b);
			default: cmp = 1'b0;              // 010/011 are not branches
		endcase
	end

endmodule

`default_nettype wire

//--- design/cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu (
	input  wire logic           clk,
	input  wire logic           rts,
	output soc_pkg::addr_t      paddr,
	output soc_pkg::word_t      pwdata,
	input  wire soc_pkg::word_t prdata,
	output logic                psel,
	output logic                penable,
	output logic                pwrite,
	output soc_pkg::strb_t      pstb,
	input  wire logic           pready,
	input  wire logic           perr,
	output logic                halted,
	output soc_pkg::addr_t      oldpc
);

	// Microcode ROM map
	//  0 fetch setup, 1 fetch access + decode
	//  2..3 ALU, 4..5 branch, 6..7 JALR
	//  8..11 load, 12..15 store (address, setup, access, end)
	localparam logic [3:0] START_ALU    = 4'd2;
	localparam logic [3:0] START_BRANCH = 4'd4;
	localparam logic [3:0] START_JALR   = 4'd6;
	localparam logic [3:0] START_LOAD   = 4'd8;
	localparam logic [3:0] START_STORE  = 4'd12;
	localparam soc_pkg::uop_t UOP_END   = soc_pkg::uop_t'(1 << soc_pkg::UOP_IDLE);

	soc_pkg::uop_t  rom [16];
	soc_pkg::uop_t  uop;           // Current microcode word
	logic [3:0]     upc;           // Index of the next word
	soc_pkg::word_t instr;
	soc_pkg::addr_t pc;            // Already points past instr
	soc_pkg::strb_t dsize;         // Lane mask of the data access
	logic           halt;
	soc_pkg::word_t regs [32];

	soc_pkg::reg_idx_t rf_wa;
	soc_pkg::word_t    rf_wd;
	logic              rf_we;
	soc_pkg::word_t    rd0, rd1, alu_b, alu_out, mem_addr, rdata_sh, load_val;
	soc_pkg::strb_t    size_mask;
	logic              cmp, stall, act, decode, ex_alu;

	initial begin
		$readmemh("microop.hex", rom);
	end

	wire [6:0]              opcode = instr[6:0];
	wire [2:0]              funct3 = instr[14:12];
	wire soc_pkg::reg_idx_t rs1    = instr[19:15];
	wire soc_pkg::reg_idx_t rs2    = instr[24:20];
	wire soc_pkg::reg_idx_t rd     = instr[11:7];

	wire soc_pkg::word_t imm_i = {{21{instr[31]}}, instr[30:20]};
	wire soc_pkg::word_t imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	wire soc_pkg::word_t imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	// U and J forms come straight off the bus while decoding
	wire soc_pkg::word_t imm_u = {prdata[31:12], 12'b0};
	wire soc_pkg::word_t imm_j = {{12{prdata[31]}}, prdata[19:12], prdata[20],
		prdata[30:21], 1'b0};

	assign rd0 = (rs1 == '0) ? '0 : regs[rs1];  // x0 is hardwired
	assign rd1 = (rs2 == '0) ? '0 : regs[rs2];

	// Bit 30 picks SUB or SRA only for register ops and right shifts
	assign ex_alu = (funct3 == 3'b101 || opcode == soc_pkg::OP_ALU) ? instr[30] : 1'b0;
	assign alu_b  = (instr[5] && opcode != soc_pkg::OP_JALR) ? rd1 : imm_i;

	alu u_alu (
		.op     ({ex_alu, funct3}),
		.a      (rd0),
		.b      (alu_b),
		.result (alu_out),
		.cmp    (cmp)
	);

	// Bus outputs come straight from the microcode word
	assign psel    = uop[soc_pkg::UOP_PSEL];
	assign penable = uop[soc_pkg::UOP_PENABLE];
	assign pwrite  = uop[soc_pkg::UOP_PWRITE];
	assign pstb    = pwrite ? dsize : '1;           // Reads always take all lanes
	assign halted  = halt;

	assign stall  = uop[soc_pkg::UOP_PSEL] & uop[soc_pkg::UOP_PENABLE] & ~pready;
	assign act    = ~halt & ~stall & ~perr;
	assign decode = act & uop[soc_pkg::UOP_LOAD_INSR];

	assign mem_addr = rd0 + ((opcode == soc_pkg::OP_STORE) ? imm_s : imm_i);
	assign rdata_sh = prdata >> {paddr[1:0], 3'b000};  // Move addressed lane to bit 0

	always_comb begin
		case (funct3[1:0])
			2'b00:   size_mask = 4'b0001;
			2'b01:   size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  load_val = {{24{rdata_sh[7]}}, rdata_sh[7:0]};    // LB
			3'b001:  load_val = {{16{rdata_sh[15]}}, rdata_sh[15:0]};  // LH
			3'b100:  load_val = {24'b0, rdata_sh[7:0]};                // LBU
			3'b101:  load_val = {16'b0, rdata_sh[15:0]};               // LHU
			default: load_val = rdata_sh;
		endcase
	end

	// One register write port shared by all writers
	always_comb begin
		rf_we = 1'b0;
		rf_wa = rd;
		rf_wd = alu_out;
		if (decode) begin
			rf_wa = prdata[11:7];
			case (prdata[6:0])
				soc_pkg::OP_LUI: begin
					rf_we = 1'b1;
					rf_wd = imm_u;
				end
				soc_pkg::OP_AUIPC: begin
					rf_we = 1'b1;
					rf_wd = oldpc + imm_u;
				end
				soc_pkg::OP_JAL: begin
					rf_we = 1'b1;
					rf_wd = pc;                         // Link address
				end
				default: rf_we = 1'b0;
			endcase
		end else if (act) begin
			if (uop[soc_pkg::UOP_STORE_ALU])
				rf_we = 1'b1;
			if (uop[soc_pkg::UOP_LOAD_PC]) begin
				rf_we = 1'b1;
				rf_wd = pc;
			end
			if (uop[soc_pkg::UOP_MEM] && uop[soc_pkg::UOP_PENABLE] &&
				!uop[soc_pkg::UOP_PWRITE]) begin
				rf_we = 1'b1;                           // Load completes with pready
				rf_wd = load_val;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rf_we)
			regs[rf_wa] <= rf_wd;
	end

	always_ff @(posedge clk or posedge rts) begin
		if (rts) begin
			pc     <= '0;
			oldpc  <= '0;
			paddr  <= '0;
			pwdata <= '0;
			instr  <= '0;
			dsize  <= '1;
			uop    <= UOP_END;                          // First cycle starts a fetch
			upc    <= '0;
			halt   <= 1'b0;
		end else if (!halt && !stall) begin
			if (perr) begin
				halt <= 1'b1;                           // Unmapped address
				uop  <= '0;                             // Drop the bus
			end else if (uop[soc_pkg::UOP_IDLE]) begin
				paddr <= pc;
				oldpc <= pc;
				pc    <= pc + 32'd4;
				uop   <= rom[0];
				upc   <= 4'd1;
			end else if (uop[soc_pkg::UOP_LOAD_INSR]) begin
				instr <= prdata;
				// All-zero word has opcode 0 and lands in default
				case (prdata[6:0])
					soc_pkg::OP_LUI, soc_pkg::OP_AUIPC: uop <= UOP_END;
					soc_pkg::OP_JAL: begin
						pc  <= oldpc + imm_j;
						uop <= UOP_END;
					end
					soc_pkg::OP_ALU, soc_pkg::OP_ALUI: begin
						uop <= rom[START_ALU];
						upc <= START_ALU + 4'd1;
					end
					soc_pkg::OP_BRANCH: begin
						uop <= rom[START_BRANCH];
						upc <= START_BRANCH + 4'd1;
					end
					soc_pkg::OP_JALR: begin
						uop <= rom[START_JALR];
						upc <= START_JALR + 4'd1;
					end
					soc_pkg::OP_LOAD: begin
						uop <= rom[START_LOAD];
						upc <= START_LOAD + 4'd1;
					end
					soc_pkg::OP_STORE: begin
						uop <= rom[START_STORE];
						upc <= START_STORE + 4'd1;
					end
					default: begin
						halt <= 1'b1;
						uop  <= '0;
					end
				endcase
			end else begin
				uop <= rom[upc];
				upc <= upc + 4'd1;
				if (uop[soc_pkg::UOP_BRANCH] && cmp)
					pc <= oldpc + imm_b;
				if (uop[soc_pkg::UOP_LOAD_PC])
					pc <= {alu_out[31:1], 1'b0};        // JALR clears bit 0
				// Address step before setup holds paddr through the access
				if (uop[soc_pkg::UOP_MEM] && !uop[soc_pkg::UOP_PSEL]) begin
					paddr  <= mem_addr;
					dsize  <= size_mask << mem_addr[1:0];
					pwdata <= rd1 << {mem_addr[1:0], 3'b000};
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/apb_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module apb_decoder #(
	parameter int NUM_BANKS  = 4,
	parameter int BANK_WORDS = 256
) (
	input  wire soc_pkg::addr_t paddr,
	input  wire logic           psel,
	input  wire logic           load_en,
	input  wire soc_pkg::addr_t load_addr,
	output logic [NUM_BANKS-1:0] sel_bank,
	output logic                no_hit,
	output logic [NUM_BANKS-1:0] bank_load_en
);

	localparam int BANK_SHIFT = 2 + $clog2(BANK_WORDS);  // Bits above one bank's bytes
	localparam int BANK_W     = 32 - BANK_SHIFT;

	logic [BANK_W-1:0] bus_bank;
	logic [BANK_W-1:0] load_bank;

	assign bus_bank  = paddr[31:BANK_SHIFT];
	assign load_bank = load_addr[31:BANK_SHIFT];

	always_comb begin
		for (int i = 0; i < NUM_BANKS; i++) begin
			sel_bank[i]     = psel && (bus_bank == BANK_W'(i));
			bank_load_en[i] = load_en && (load_bank == BANK_W'(i));
		end
	end

	// Above the last bank; boot loads there are simply dropped
	assign no_hit = psel && (bus_bank >= BANK_W'(NUM_BANKS));

endmodule

`default_nettype wire

//--- design/apb_ram.sv
`timescale 1ns/10ps
`default_nettype none

module apb_ram #(
	parameter int BANK_WORDS  = 256,
	parameter int WAIT_STATES = 1
) (
	input  wire logic           clk,
	input  wire logic           rts,
	input  wire logic           sel,
	input  wire logic           penable,
	input  wire logic           pwrite,
	input  wire soc_pkg::addr_t paddr,
	input  wire soc_pkg::word_t pwdata,
	input  wire soc_pkg::strb_t pstb,
	output soc_pkg::word_t      prdata,
	output logic                pready,
	input  wire logic           load_en,
	input  wire soc_pkg::addr_t load_addr,
	input  wire soc_pkg::word_t load_data
);

	localparam int IDX_W = $clog2(BANK_WORDS);
	localparam logic [1:0] LAST_WAIT = 2'(WAIT_STATES == 0 ? 0 : WAIT_STATES - 1);

	typedef enum logic [1:0] {bank_idle, bank_wait, bank_ready} bank_state_t;

	bank_state_t    state;
	logic [1:0]     wait_cnt;
	soc_pkg::word_t mem [BANK_WORDS];
	logic [IDX_W-1:0] idx, load_idx;

	assign idx      = paddr[2 +: IDX_W];
	assign load_idx = load_addr[2 +: IDX_W];
	assign prdata   = mem[idx];
	assign pready   = sel && penable && (state == bank_ready);

	always_ff @(posedge clk or posedge rts) begin
		if (rts) begin
			state    <= bank_idle;
			wait_cnt <= '0;
		end else begin
			case (state)
				bank_idle: if (sel && !penable) begin   // Setup phase seen
					state    <= (WAIT_STATES == 0) ? bank_ready : bank_wait;
					wait_cnt <= '0;
				end
				bank_wait: if (wait_cnt == LAST_WAIT)
					state <= bank_ready;
				else
					wait_cnt <= wait_cnt + 2'd1;
				default: if (pready || !sel)
					state <= bank_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_en)
			mem[load_idx] <= load_data;                 // Boot load, whole word
		else if (pready && pwrite)
			for (int b = 0; b < 4; b++)
				if (pstb[b])
					mem[idx][8*b +: 8] <= pwdata[8*b +: 8];
	end

endmodule

`default_nettype wire

//--- design/apb_resp_mux.sv
`timescale 1ns/10ps
`default_nettype none

module apb_resp_mux #(
	parameter int NUM_BANKS = 4
) (
	input  wire logic [NUM_BANKS-1:0] sel_bank,
	input  wire logic                 no_hit,
	input  wire logic                 penable,
	input  wire soc_pkg::word_t       bank_prdata [NUM_BANKS],
	input  wire logic [NUM_BANKS-1:0] bank_pready,
	output soc_pkg::word_t            prdata,
	output logic                      pready,
	output logic                      perr
);

	// At most one select is active, so an OR tree is enough
	always_comb begin
		prdata = '0;
		for (int i = 0; i < NUM_BANKS; i++)
			if (sel_bank[i])
				prdata = prdata | bank_prdata[i];
	end

	assign perr   = no_hit && penable;               // Error answers at once
	assign pready = |(sel_bank & bank_pready) || perr;

endmodule

`default_nettype wire

//--- design/soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_top #(
	parameter int NUM_BANKS   = 4,
	parameter int BANK_WORDS  = 256,
	parameter int WAIT_STATES = 1
) (
	input  wire logic           clk,
	input  wire logic           rts,
	input  wire logic           load_en,
	input  wire soc_pkg::addr_t load_addr,
	input  wire soc_pkg::word_t load_data,
	output logic                halted,
	output soc_pkg::addr_t      oldpc,
	output soc_pkg::addr_t      bus_addr,
	output soc_pkg::word_t      bus_wdata,
	output soc_pkg::strb_t      bus_strb,
	output logic                bus_write,
	output logic                bus_valid,
	output logic                bus_ready
);

	soc_pkg::addr_t paddr;
	soc_pkg::word_t pwdata, prdata;
	soc_pkg::strb_t pstb;
	logic psel, penable, pwrite, pready, perr, no_hit;
	logic [NUM_BANKS-1:0] sel_bank, bank_load_en, bank_pready;
	soc_pkg::word_t bank_prdata [NUM_BANKS];

	cpu u_cpu (
		.clk (clk), .rts (rts),
		.paddr (paddr), .pwdata (pwdata), .prdata (prdata),
		.psel (psel), .penable (penable), .pwrite (pwrite), .pstb (pstb),
		.pready (pready), .perr (perr),
		.halted (halted), .oldpc (oldpc)
	);

	apb_decoder #(.NUM_BANKS (NUM_BANKS), .BANK_WORDS (BANK_WORDS)) u_decoder (
		.paddr (paddr), .psel (psel),
		.load_en (load_en), .load_addr (load_addr),
		.sel_bank (sel_bank), .no_hit (no_hit), .bank_load_en (bank_load_en)
	);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
		apb_ram #(.BANK_WORDS (BANK_WORDS), .WAIT_STATES (WAIT_STATES)) u_ram (
			.clk (clk), .rts (rts),
			.sel (sel_bank[i]), .penable (penable), .pwrite (pwrite),
			.paddr (paddr), .pwdata (pwdata), .pstb (pstb),
			.prdata (bank_prdata[i]), .pready (bank_pready[i]),
			.load_en (bank_load_en[i]), .load_addr (load_addr), .load_data (load_data)
		);
	end

	apb_resp_mux #(.NUM_BANKS (NUM_BANKS)) u_resp_mux (
		.sel_bank (sel_bank), .no_hit (no_hit), .penable (penable),
		.bank_prdata (bank_prdata), .bank_pready (bank_pready),
		.prdata (prdata), .pready (pready), .perr (perr)
	);

	assign bus_addr  = paddr;
	assign bus_wdata = pwdata;
	assign bus_strb  = pstb;
	assign bus_write = pwrite;
	assign bus_valid = psel & penable;
	assign bus_ready = pready & ~perr;                   // Error responses never complete

endmodule

`default_nettype wire

//--- test/soc_checker.sv
`timescale 1ns/10ps
`default_nettype none

module soc_checker (
	input wire logic           clk,
	input wire logic           rts,
	input wire logic           psel,
	input wire logic           penable,
	input wire soc_pkg::addr_t paddr,
	input wire logic           halted
);

	a_enable_needs_sel: assert property (@(posedge clk) disable iff (rts)
		penable |-> psel)
		else $error("penable high without psel");

	a_setup_then_access: assert property (@(posedge clk) disable iff (rts)
		(psel && !penable) |=> (psel && penable))
		else $error("setup phase not followed by access phase");

	// Accesses are never back to back, so psel on two cycles means one access
	a_addr_stable: assert property (@(posedge clk) disable iff (rts)
		(psel && $past(psel)) |-> $stable(paddr))
		else $error("paddr changed during an access");

	a_halt_sticky: assert property (@(posedge clk) disable iff (rts)
		$past(halted) |-> halted)
		else $error("halted fell without reset");

	a_no_psel_halted: assert property (@(posedge clk) disable iff (rts)
		halted |-> !psel)
		else $error("psel while halted");

endmodule

bind soc_top soc_checker u_checker (
	.clk     (clk),
	.rts     (rts),
	.psel    (psel),
	.penable (penable),
	.paddr   (paddr),
	.halted  (halted)
);

`default_nettype wire

//--- test/tb_soc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_soc #(
	parameter int WAIT_STATES = 1
);

	localparam int NUM_BANKS  = 4;
	localparam int BANK_WORDS = 256;
	localparam int MEM_WORDS  = NUM_BANKS * BANK_WORDS;
	localparam int MEM_BYTES  = MEM_WORDS * 4;

	logic clk, rts, load_en, halted, bus_write, bus_valid, bus_ready, first_fetch;
	soc_pkg::addr_t load_addr, oldpc, bus_addr;
	soc_pkg::word_t load_data, bus_wdata;
	soc_pkg::strb_t bus_strb;

	logic [31:0] img [MEM_WORDS];   // Image written through the load port
	logic [31:0] mm [MEM_WORDS];    // Model memory
	logic [31:0] xr [32];           // Model registers
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] exp_strb [$];
	logic [31:0] exp_pc [$];        // Address of each store instruction

	soc_top #(.NUM_BANKS (NUM_BANKS), .BANK_WORDS (BANK_WORDS),
		.WAIT_STATES (WAIT_STATES)) u_dut (
		.clk (clk), .rts (rts), .load_en (load_en), .load_addr (load_addr),
		.load_data (load_data), .halted (halted), .oldpc (oldpc), .bus_addr (bus_addr),
		.bus_wdata (bus_wdata), .bus_strb (bus_strb), .bus_write (bus_write),
		.bus_valid (bus_valid), .bus_ready (bus_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_fail($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], soc_pkg::OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], soc_pkg::OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, soc_pkg::OP_JAL};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (f)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return sa >>> b[4:0];     // Arithmetic shift keeps the sign
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken(input logic [2:0] f, input logic [31:0] a,
		input logic [31:0] b);
		case (f)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// Forward jumps only so the program always reaches the zero word
	task automatic gen_program();
		int n, kind;
		logic [4:0] rd, rs1, rs2;
		logic [2:0] f3;
		logic [11:0] imm;
		logic alt;
		for (int i = 0; i < MEM_WORDS; i++)
			img[i] = $urandom;
		n = 0;
		for (int r = 1; r < 30; r++)
			img[n++] = enc_i(12'($urandom), 5'd0, 3'd0, 5'(r), soc_pkg::OP_ALUI);
		img[n++] = enc_i(12'h600, 5'd0, 3'd0, 5'd30, soc_pkg::OP_ALUI);  // Data area base
		img[n++] = enc_i(12'h700, 5'd0, 3'd0, 5'd31, soc_pkg::OP_ALUI);  // Result area base
		while (n < 121) begin
			kind = $urandom % 9;
			rd   = 5'(1 + $urandom % 29);
			rs1  = 5'($urandom % 30);
			rs2  = 5'($urandom % 30);
			f3   = 3'($urandom);
			alt  = 1'($urandom);
			imm  = 12'($urandom);
			case (kind)
				1: begin
					if (f3 == 3'd1 || f3 == 3'd5)
						imm[11:5] = (f3 == 3'd5 && alt) ? 7'h20 : 7'h00;
					img[n++] = enc_i(imm, rs1, f3, rd, soc_pkg::OP_ALUI);
				end
				2: img[n++] = {20'($urandom), rd, alt ? soc_pkg::OP_LUI : soc_pkg::OP_AUIPC};
				3: begin
					f3 = (f3 == 3'd3 || f3 > 3'd5) ? 3'd2 : f3;
					imm = 12'(($urandom % 64) & ~((1 << f3[1:0]) - 1));  // Natural alignment
					img[n++] = enc_i(imm, 5'd30, f3, rd, soc_pkg::OP_LOAD);
				end
				4: begin
					f3 = 3'($urandom % 3);
					imm = 12'(($urandom % 64) & ~((1 << f3[1:0]) - 1));
					img[n++] = enc_s(imm, rs2, 5'd30, f3);
				end
				5: begin
					f3 = (f3 == 3'd2 || f3 == 3'd3) ? 3'd0 : f3;
					img[n++] = enc_b(13'(4 * (1 + $urandom % 4)), rs2, rs1, f3);
				end
				6: img[n++] = enc_j(21'(4 * (1 + $urandom % 4)), rd);
				7: begin
					imm = 12'(4 * (n + 1 + $urandom % 3) + $urandom % 2);  // Absolute target
					img[n++] = enc_i(imm, 5'd0, 3'd0, rd, soc_pkg::OP_JALR);
				end
				default: img[n++] = {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
					rs2, rs1, f3, rd, soc_pkg::OP_ALU};
			endcase
		end
		for (int r = 1; r < 32; r++)
			img[n++] = enc_s(12'((r - 1) * 4), 5'(r), 5'd31, 3'd2);
		img[n] = 32'h0;
	endtask

	task automatic gen_err_program();
		for (int i = 0; i < MEM_WORDS; i++)
			img[i] = $urandom;
		img[0] = enc_i(12'h123, 5'd0, 3'd0, 5'd5, soc_pkg::OP_ALUI);
		img[1] = {20'h00002, 5'd6, soc_pkg::OP_LUI};     // x6 points past the banks
		img[2] = enc_s(12'h100, 5'd5, 5'd0, 3'd2);
		img[3] = enc_s(12'h000, 5'd5, 5'd6, 3'd2);
		img[4] = enc_s(12'h104, 5'd5, 5'd0, 3'd2);       // Never reached
		img[5] = 32'h0;
	endtask

	task automatic run_model();
		logic [31:0] pc, npc, in, a, b, r, ea, w, m;
		logic [2:0] f3;
		logic done, wr;
		int steps;
		pc = 0;
		done = 0;
		steps = 0;
		for (int i = 0; i < 32; i++)
			xr[i] = 0;
		while (!done) begin
			if (steps++ > 4000)
				stop_fail("Reference model did not reach a halt");
			in = mm[pc[11:2]];
			a = xr[in[19:15]];
			b = xr[in[24:20]];
			f3 = in[14:12];
			r = 0;
			wr = 1;
			npc = pc + 4;
			case (in[6:0])
				soc_pkg::OP_LUI: r = {in[31:12], 12'b0};
				soc_pkg::OP_AUIPC: r = pc + {in[31:12], 12'b0};
				soc_pkg::OP_JAL: begin
					r = pc + 4;
					npc = pc + {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
				end
				soc_pkg::OP_JALR: begin
					r = pc + 4;
					npc = (a + {{20{in[31]}}, in[31:20]}) & ~32'd1;
				end
				soc_pkg::OP_BRANCH: begin
					wr = 0;
					if (taken(f3, a, b))
						npc = pc + {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
				end
				soc_pkg::OP_ALUI:
					r = alu_ref(f3, f3 == 3'd5 && in[30], a, {{20{in[31]}}, in[31:20]});
				soc_pkg::OP_ALU: r = alu_ref(f3, in[30], a, b);
				soc_pkg::OP_LOAD: begin
					ea = a + {{20{in[31]}}, in[31:20]};
					done = (ea >= MEM_BYTES);
					w = mm[ea[11:2]] >> {ea[1:0], 3'b000};
					case (f3)
						3'd0: r = {{24{w[7]}}, w[7:0]};
						3'd1: r = {{16{w[15]}}, w[15:0]};
						3'd4: r = {24'b0, w[7:0]};
						3'd5: r = {16'b0, w[15:0]};
						default: r = w;
					endcase
				end
				soc_pkg::OP_STORE: begin
					wr = 0;
					ea = a + {{20{in[31]}}, in[31:25], in[11:7]};
					done = (ea >= MEM_BYTES);    // Out of range ends in an error halt
					m = (f3 == 3'd0) ? 32'hff : (f3 == 3'd1) ? 32'hffff : 32'hffffffff;
					m = m << {ea[1:0], 3'b000};
					w = (b << {ea[1:0], 3'b000}) & m;
					if (!done) begin
						mm[ea[11:2]] = (mm[ea[11:2]] & ~m) | w;
						exp_addr.push_back(ea);
						exp_data.push_back(w);
						exp_strb.push_back({28'b0, m[24], m[16], m[8], m[0]});
						exp_pc.push_back(pc);
					end
				end
				default: done = 1;
			endcase
			if (!done) begin
				if (wr && in[11:7] != 5'd0)
					xr[in[11:7]] = r;
				pc = npc;
			end
		end
	endtask

	task automatic run_program(input logic err_case);
		int cyc;
		if (err_case)
			gen_err_program();
		else
			gen_program();
		for (int i = 0; i < MEM_WORDS; i++)
			mm[i] = img[i];
		run_model();
		@(posedge clk);
		rts <= 1'b1;
		for (int i = 0; i < MEM_WORDS; i++) begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_addr <= i * 4;
			load_data <= img[i];
		end
		@(posedge clk);
		load_en <= 1'b0;
		repeat (5) @(posedge clk);
		first_fetch = 1'b1;
		rts <= 1'b0;
		@(negedge clk);
		check("bus_valid", {31'b0, bus_valid}, 32'h0);
		check("halted", {31'b0, halted}, 32'h0);
		for (cyc = 0; cyc < 60000 && !halted; cyc++)
			@(negedge clk);
		if (!halted)
			stop_fail("Timeout waiting for the core to halt");
		repeat (20) @(negedge clk);         // Window for stray accesses
		if (exp_addr.size() != 0)
			stop_fail("Core halted before all expected writes");
	endtask

	function automatic logic [31:0] lane_mask(input logic [3:0] s);
		return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
	endfunction

	always @(negedge clk) begin
		if (!rts) begin
			if (halted && bus_valid)
				stop_fail("Bus access after halt");
			if (bus_valid && bus_ready && first_fetch) begin
				check("bus_addr", bus_addr, 32'h0);    // First fetch comes from address 0
				check("bus_write", {31'b0, bus_write}, 32'h0);
				check("oldpc", oldpc, 32'h0);
				first_fetch = 1'b0;
			end
			if (bus_valid && bus_ready && bus_write) begin
				if (exp_addr.size() == 0)
					stop_fail("Write beyond the expected sequence");
				check("oldpc", oldpc, exp_pc.pop_front());
				check("bus_addr", bus_addr, exp_addr.pop_front());
				check("bus_strb", {28'b0, bus_strb}, exp_strb.pop_front());
				check("bus_wdata", bus_wdata & lane_mask(bus_strb), exp_data.pop_front());
			end
		end
	end

	initial begin
		rts = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		first_fetch = 1'b0;
		void'($urandom(15205));
		run_program(1'b0);
		run_program(1'b0);
		run_program(1'b1);                  // Unmapped store
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- microop.hex
// One 12-bit microcode word per line, ROM address 0 to 15
001
00B
804
800
020
800
040
800
010
011
013
800
010
111
113
800

//--- all.f
design/soc_pkg.sv
design/alu.sv
design/cpu.sv
design/apb_decoder.sv
design/apb_ram.sv
design/apb_resp_mux.sv
design/soc_top.sv
test/soc_checker.sv
test/tb_soc.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator for WAIT_STATES 0 and 1
set -u
cd "$(dirname "$0")" || exit 1

for ws in 0 1; do
	obj="obj_ws${ws}"
	log="sim_ws${ws}.log"
	verilator --binary --timing --assert -Wno-fatal --top-module tb_soc \
		-GWAIT_STATES=${ws} -f all.f --Mdir "${obj}" -o sim
	if [ $? -ne 0 ]; then
		echo "Build failed for WAIT_STATES=${ws}"
		exit 1
	fi
	"./${obj}/sim" > "${log}" 2>&1
	status=$?
	cat "${log}"
	if ! grep -q "TESTBENCH PASSED" "${log}"; then
		echo "Simulation failed for WAIT_STATES=${ws} (exit status ${status})"
		exit 1
	fi
done
echo "All runs passed"
exit 0
